/* decode_select.sv */
module decode_select (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  logic [31:0]               pc,
    input  logic [31:0]               inst,
    input  logic [1:0]                plv,
    input  la_decode_pkg::decoded_t   dec_ri14,
    input  la_decode_pkg::decoded_t   dec_ri12,
    output la_decode_pkg::decoded_t   sel_dec,
    output logic                      out_valid,
    output logic [31:0]               out_pc,
    output logic [31:0]               out_inst,
    output la_decode_pkg::decoded_t   out_dec,
    output la_decode_pkg::exc_cause_e out_exc
);
    import la_decode_pkg::*;

    exc_cause_e exc;
    decoded_t   fin_dec;

    // opcode spaces are disjoint, at most one hit
    assign sel_dec = dec_ri14.hit ? dec_ri14 : dec_ri12;

    always_comb begin
        exc = EXC_NONE;
        if (!sel_dec.hit) begin
            exc = EXC_INE;
        end else if (sel_dec.is_privilege && plv != 2'd0) begin
            exc = EXC_IPE;   // csr access outside kernel mode
        end

        fin_dec = sel_dec;
        if (exc != EXC_NONE) begin
            fin_dec.reg_write_en = 1'b0;   // faulting word must not retire
            fin_dec.csr_write_en = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_pc   <= pc;
            out_inst <= inst;
            out_dec  <= fin_dec;
            out_exc  <= exc;
        end
    end

endmodule

/* decoder_2ri12.sv */
module decoder_2ri12 (
    input  logic [31:0]             inst,
    output la_decode_pkg::decoded_t dec
);
    import la_decode_pkg::*;

    logic [9:0]  opcode;
    logic [11:0] si12;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    assign opcode   = inst[31:22];
    assign si12     = inst[21:10];
    assign rj       = inst[9:5];
    assign rd       = inst[4:0];
    assign imm_sext = {{20{si12[11]}}, si12};
    assign imm_zext = {20'b0, si12};   // logic ops use ui12

    always_comb begin
        dec = '0;

        // common shape for the whole format
        dec.reg1_read_en   = 1'b1;
        dec.reg1_read_addr = rj;
        dec.reg_write_en   = 1'b1;
        dec.reg_write_addr = rd;
        dec.imm            = imm_sext;

        case (opcode)
            OP12_ADDI: begin
                dec.hit    = 1'b1;
                dec.aluop  = ALU_ADD;
                dec.alusel = SEL_ARITH;
            end
            OP12_SLTI: begin
                dec.hit    = 1'b1;
                dec.aluop  = ALU_SLT;
                dec.alusel = SEL_ARITH;
            end
            OP12_SLTUI: begin
                dec.hit    = 1'b1;
                dec.aluop  = ALU_SLTU;   // signed imm, unsigned compare
                dec.alusel = SEL_ARITH;
            end
            OP12_ANDI: begin
                dec.hit    = 1'b1;
                dec.aluop  = ALU_AND;
                dec.alusel = SEL_LOGIC;
                dec.imm    = imm_zext;
            end
            OP12_ORI: begin
                dec.hit    = 1'b1;
                dec.aluop  = ALU_OR;
                dec.alusel = SEL_LOGIC;
                dec.imm    = imm_zext;
            end
            OP12_XORI: begin
                dec.hit    = 1'b1;
                dec.aluop  = ALU_XOR;
                dec.alusel = SEL_LOGIC;
                dec.imm    = imm_zext;
            end
            OP12_LDW: begin
                dec.hit    = 1'b1;
                dec.aluop  = ALU_LDW;
                dec.alusel = SEL_LOAD_STORE;
            end
            OP12_STW: begin
                dec.hit            = 1'b1;
                dec.aluop          = ALU_STW;
                dec.alusel         = SEL_LOAD_STORE;
                dec.reg_write_en   = 1'b0;
                dec.reg_write_addr = 5'd0;
                dec.reg2_read_en   = 1'b1;
                dec.reg2_read_addr = rd;   // store data
            end
            default: begin
                dec = '0;   // no claim, drop the common fields
            end
        endcase
    end

endmodule

/* decoder_2ri14.sv */
module decoder_2ri14 (
    input  logic [31:0]             inst,
    output la_decode_pkg::decoded_t dec
);
    import la_decode_pkg::*;

    logic [7:0]  opcode;
    logic [13:0] si14;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic [31:0] imm_word;

    assign opcode   = inst[31:24];
    assign si14     = inst[23:10];
    assign rj       = inst[9:5];
    assign rd       = inst[4:0];
    assign imm_word = {{16{si14[13]}}, si14, 2'b00};   // word offset, byte aligned

    always_comb begin
        dec = '0;
        case (opcode)
            OP14_LLW: begin
                dec.hit            = 1'b1;
                dec.aluop          = ALU_LLW;
                dec.alusel         = SEL_LOAD_STORE;
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = rd;
                dec.reg1_read_en   = 1'b1;
                dec.reg1_read_addr = rj;   // base address
                dec.imm            = imm_word;
                dec.csr_read_en    = 1'b1;
                dec.csr_addr       = CSR_LLBCTL;
            end
            OP14_SCW: begin
                dec.hit            = 1'b1;
                dec.aluop          = ALU_SCW;
                dec.alusel         = SEL_LOAD_STORE;
                dec.reg_write_en   = 1'b1;   // success flag back to rd
                dec.reg_write_addr = rd;
                dec.reg1_read_en   = 1'b1;
                dec.reg1_read_addr = rj;
                dec.reg2_read_en   = 1'b1;
                dec.reg2_read_addr = rd;   // store data
                dec.imm            = imm_word;
                dec.csr_read_en    = 1'b1;
                dec.csr_addr       = CSR_LLBCTL;
            end
            OP14_CSR: begin
                dec.hit            = 1'b1;
                dec.is_privilege   = 1'b1;
                dec.alusel         = SEL_CSR;
                dec.reg_write_en   = 1'b1;   // old csr value always lands in rd
                dec.reg_write_addr = rd;
                dec.csr_read_en    = 1'b1;
                dec.csr_addr       = si14;
                case (rj)
                    CSR_SUB_RD: begin
                        dec.aluop = ALU_CSRRD;
                    end
                    CSR_SUB_WR: begin
                        dec.aluop          = ALU_CSRWR;
                        dec.reg1_read_en   = 1'b1;
                        dec.reg1_read_addr = rd;
                        dec.csr_write_en   = 1'b1;
                    end
                    default: begin
                        dec.aluop          = ALU_CSRXCHG;
                        dec.reg1_read_en   = 1'b1;
                        dec.reg1_read_addr = rd;   // new value
                        dec.reg2_read_en   = 1'b1;
                        dec.reg2_read_addr = rj;   // write mask
                        dec.csr_write_en   = 1'b1;
                    end
                endcase
            end
            default: begin
                dec = '0;   // not a 2ri14 word
            end
        endcase
    end

endmodule

/* flist.f */
la_decode_pkg.sv
decoder_2ri14.sv
decoder_2ri12.sv
decode_select.sv
regfile.sv
id_stage.sv
tb_id_stage.sv

/* id_stage.sv */
module id_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  logic [31:0]               pc,
    input  logic [31:0]               inst,
    input  logic [1:0]                plv,
    input  logic                      wb_en,
    input  logic [4:0]                wb_addr,
    input  logic [31:0]               wb_data,
    output logic                      out_valid,
    output logic [31:0]               out_pc,
    output logic [31:0]               out_inst,
    output la_decode_pkg::decoded_t   out_dec,
    output la_decode_pkg::exc_cause_e out_exc,
    output logic [31:0]               rj_value,
    output logic [31:0]               rk_value
);
    import la_decode_pkg::*;

    decoded_t dec_ri14;
    decoded_t dec_ri12;
    decoded_t sel_dec;

    decoder_2ri14 u_dec_ri14 (
        .inst (inst),
        .dec  (dec_ri14)
    );

    decoder_2ri12 u_dec_ri12 (
        .inst (inst),
        .dec  (dec_ri12)
    );

    decode_select u_select (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .pc        (pc),
        .inst      (inst),
        .plv       (plv),
        .dec_ri14  (dec_ri14),
        .dec_ri12  (dec_ri12),
        .sel_dec   (sel_dec),
        .out_valid (out_valid),
        .out_pc    (out_pc),
        .out_inst  (out_inst),
        .out_dec   (out_dec),
        .out_exc   (out_exc)
    );

    // operands are captured on the same edge as out_dec
    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rd_en   (in_valid),
        .raddr1  (sel_dec.reg1_read_addr),
        .raddr2  (sel_dec.reg2_read_addr),
        .ren1    (sel_dec.reg1_read_en),
        .ren2    (sel_dec.reg2_read_en),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .rdata1  (rj_value),
        .rdata2  (rk_value)
    );

endmodule

/* la_decode_pkg.sv */
package la_decode_pkg;

    // 2RI14 major opcodes, inst[31:24]
    localparam logic [7:0] OP14_LLW = 8'h20;
    localparam logic [7:0] OP14_SCW = 8'h21;
    localparam logic [7:0] OP14_CSR = 8'h04;

    // csr group sub-op lives in the rj field
    localparam logic [4:0] CSR_SUB_RD = 5'd0;
    localparam logic [4:0] CSR_SUB_WR = 5'd1;

    // 2RI12 major opcodes, inst[31:22]
    localparam logic [9:0] OP12_SLTI  = 10'h008;
    localparam logic [9:0] OP12_SLTUI = 10'h009;
    localparam logic [9:0] OP12_ADDI  = 10'h00a;
    localparam logic [9:0] OP12_ANDI  = 10'h00d;
    localparam logic [9:0] OP12_ORI   = 10'h00e;
    localparam logic [9:0] OP12_XORI  = 10'h00f;
    localparam logic [9:0] OP12_LDW   = 10'h0a2;
    localparam logic [9:0] OP12_STW   = 10'h0a6;

    localparam logic [13:0] CSR_LLBCTL = 14'h060;   // ll/sc link bit control

    typedef enum logic [7:0] {
        ALU_NOP     = 8'h00,
        ALU_ADD     = 8'h01,
        ALU_SLT     = 8'h02,
        ALU_SLTU    = 8'h03,
        ALU_AND     = 8'h04,
        ALU_OR      = 8'h05,
        ALU_XOR     = 8'h06,
        ALU_LDW     = 8'h10,
        ALU_STW     = 8'h11,
        ALU_LLW     = 8'h12,
        ALU_SCW     = 8'h13,
        ALU_CSRRD   = 8'h20,
        ALU_CSRWR   = 8'h21,
        ALU_CSRXCHG = 8'h22
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NOP        = 3'd0,
        SEL_ARITH      = 3'd1,
        SEL_LOGIC      = 3'd2,
        SEL_LOAD_STORE = 3'd3,
        SEL_CSR        = 3'd4
    } alu_sel_e;

    // ecode values as in the estat register
    typedef enum logic [6:0] {
        EXC_NONE = 7'h00,
        EXC_INE  = 7'h0d,
        EXC_IPE  = 7'h0e
    } exc_cause_e;

    typedef struct packed {
        logic        hit;               // word belongs to this format
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        alu_op_e     aluop;
        alu_sel_e    alusel;
        logic [31:0] imm;
        logic        reg1_read_en;
        logic [4:0]  reg1_read_addr;
        logic        reg2_read_en;
        logic [4:0]  reg2_read_addr;
        logic        is_privilege;
        logic        csr_read_en;
        logic        csr_write_en;
        logic [13:0] csr_addr;
    } decoded_t;

endpackage

/* regfile.sv */
module regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic        rd_en,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic        ren1,
    input  logic        ren2,
    input  logic        wb_en,
    input  logic [4:0]  wb_addr,
    input  logic [31:0] wb_data,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    // one read port, r0 and disabled ports give zero
    function automatic logic [31:0] read_port(input logic en, input logic [4:0] addr);
        logic [31:0] val;
        val = regs[addr];
        if (!en || addr == 5'd0) begin
            val = 32'b0;
        end else if (wb_en && wb_addr == addr) begin
            val = wb_data;   // same-edge writeback wins
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wb_en && wb_addr != 5'd0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata1 <= 32'b0;
            rdata2 <= 32'b0;
        end else if (rd_en) begin
            rdata1 <= read_port(ren1, raddr1);
            rdata2 <= read_port(ren2, raddr2);
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_id_stage -o sim_tb_id_stage

out=$(./obj_dir/sim_tb_id_stage)
echo "$out"

echo "$out" | grep -qx "test passed"

/* tb_id_stage.sv */
module tb_id_stage;
    import la_decode_pkg::*;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        decoded_t    dec;
        exc_cause_e  exc;
        logic [31:0] rj;
        logic [31:0] rk;
    } expect_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_t;

    localparam wb_t NO_WB = '0;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        in_valid = 1'b0;
    logic [31:0] pc = 32'h1c00_0000;
    logic [31:0] inst = 32'b0;
    logic [1:0]  plv = 2'd0;
    logic        wb_en = 1'b0;
    logic [4:0]  wb_addr = 5'd0;
    logic [31:0] wb_data = 32'b0;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    decoded_t    out_dec;
    exc_cause_e  out_exc;
    logic [31:0] rj_value;
    logic [31:0] rk_value;

    logic [31:0] shadow [32] = '{default: 32'b0};   // mirrors every writeback
    logic [9:0]  op12_list [8] = '{OP12_ADDI, OP12_SLTI, OP12_SLTUI, OP12_ANDI,
                                   OP12_ORI, OP12_XORI, OP12_LDW, OP12_STW};
    expect_t     exp_q [$];
    string       name_q [$];
    logic        issued_any = 1'b0;
    int          checks = 0;
    int          value_errors = 0;
    int          latency_errors = 0;
    int          timeouts = 0;

    id_stage dut0 (.*);

    always #5 clk = ~clk;

    assert property (@(posedge clk) disable iff (reset) out_valid == $past(in_valid))
        else begin
            latency_errors++;
            $display("out_valid did not follow in_valid after exactly one cycle");
        end

    function automatic void model_decode(input logic [31:0] w, input logic [1:0] lvl,
                                         output decoded_t d, output exc_cause_e e);
        logic [4:0] rj;
        logic [4:0] rd;
        rj = w[9:5];
        rd = w[4:0];
        d = '0;
        e = EXC_NONE;
        d.hit = 1'b1;
        d.reg_write_en = 1'b1;
        d.reg_write_addr = rd;
        d.reg1_read_en = 1'b1;
        d.reg1_read_addr = rj;
        d.csr_read_en = 1'b1;
        if (w[31:24] == OP14_LLW || w[31:24] == OP14_SCW) begin
            d.aluop = (w[31:24] == OP14_SCW) ? ALU_SCW : ALU_LLW;
            d.alusel = SEL_LOAD_STORE;
            d.imm = 32'($signed(w[23:10])) << 2;
            d.reg2_read_en = (d.aluop == ALU_SCW);
            d.csr_addr = CSR_LLBCTL;
        end else if (w[31:24] == OP14_CSR) begin
            d.aluop = (rj == CSR_SUB_RD) ? ALU_CSRRD :
                      (rj == CSR_SUB_WR) ? ALU_CSRWR : ALU_CSRXCHG;
            d.alusel = SEL_CSR;
            d.is_privilege = 1'b1;
            d.csr_addr = w[23:10];
            d.reg1_read_en = (d.aluop != ALU_CSRRD);
            d.reg1_read_addr = d.reg1_read_en ? rd : 5'd0;   // rd is the source here
            d.csr_write_en = d.reg1_read_en;
            d.reg2_read_en = (d.aluop == ALU_CSRXCHG);
        end else begin
            d.csr_read_en = 1'b0;
            d.imm = 32'($signed(w[21:10]));
            case (w[31:22])
                OP12_ADDI:  d.aluop = ALU_ADD;
                OP12_SLTI:  d.aluop = ALU_SLT;
                OP12_SLTUI: d.aluop = ALU_SLTU;
                OP12_ANDI:  d.aluop = ALU_AND;
                OP12_ORI:   d.aluop = ALU_OR;
                OP12_XORI:  d.aluop = ALU_XOR;
                OP12_LDW:   d.aluop = ALU_LDW;
                OP12_STW:   d.aluop = ALU_STW;
                default:    d.hit = 1'b0;
            endcase
            if (d.aluop inside {ALU_AND, ALU_OR, ALU_XOR}) begin
                d.alusel = SEL_LOGIC;
                d.imm = {20'b0, w[21:10]};   // zero extended
            end else begin
                d.alusel = (d.aluop inside {ALU_LDW, ALU_STW}) ? SEL_LOAD_STORE : SEL_ARITH;
            end
            d.reg_write_en = (d.aluop != ALU_STW);
            d.reg2_read_en = (d.aluop == ALU_STW);
        end
        d.reg2_read_addr = !d.reg2_read_en ? 5'd0 : (d.aluop == ALU_CSRXCHG) ? rj : rd;
        d.reg_write_addr = d.reg_write_en ? d.reg_write_addr : 5'd0;
        if (!d.hit) begin
            d = '0;
            e = EXC_INE;
        end else if (d.is_privilege && lvl != 2'd0) begin
            e = EXC_IPE;
            d.reg_write_en = 1'b0;
            d.csr_write_en = 1'b0;
        end
    endfunction

    task automatic drive(input string test, input logic valid, input logic [31:0] word,
                         input logic [1:0] lvl, input wb_t wb);
        expect_t item;
        @(posedge clk);
        #1;
        in_valid = valid;
        inst = word;
        plv = lvl;
        {wb_en, wb_addr, wb_data} = wb;
        if (wb.en && wb.addr != 5'd0) begin
            shadow[wb.addr] = wb.data;   // same-edge read sees it
        end
        if (valid) begin
            pc = pc + 32'd4;
            issued_any = 1'b1;
            item.pc = pc;
            item.inst = word;
            model_decode(word, lvl, item.dec, item.exc);
            item.rj = item.dec.reg1_read_en ? shadow[item.dec.reg1_read_addr] : 32'b0;
            item.rk = item.dec.reg2_read_en ? shadow[item.dec.reg2_read_addr] : 32'b0;
            exp_q.push_back(item);
            name_q.push_back(test);
        end
    endtask

    task automatic drain(input string test);
        int waited;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        {wb_en, wb_addr, wb_data} = NO_WB;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("%s: no out_valid within 20 cycles, %0d instructions outstanding",
                     test, exp_q.size());
        end
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [95:0] exp_val, input logic [95:0] act_val);
        checks++;
        assert (act_val === exp_val) else begin
            value_errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test, field, exp_val, act_val);
        end
    endtask

    always @(negedge clk) begin
        expect_t item;
        string   test;
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                value_errors++;
                $display("out_valid was high with no instruction outstanding");
            end else begin
                item = exp_q.pop_front();
                test = name_q.pop_front();
                check_value(test, "pc", 96'(item.pc), 96'(out_pc));
                check_value(test, "inst", 96'(item.inst), 96'(out_inst));
                check_value(test, "decoded", 96'(item.dec), 96'(out_dec));
                check_value(test, "imm", 96'(item.dec.imm), 96'(out_dec.imm));
                check_value(test, "exception", 96'(item.exc), 96'(out_exc));
                check_value(test, "rj_value", 96'(item.rj), 96'(rj_value));
                check_value(test, "rk_value", 96'(item.rk), 96'(rk_value));
            end
        end else if (!reset && !issued_any) begin
            check_value("after_reset", "rj_value", 96'(0), 96'(rj_value));
            check_value("after_reset", "rk_value", 96'(0), 96'(rk_value));
        end
    end

    initial begin
        logic [31:0] word;
        logic [4:0]  r;
        logic [7:0]  op8;
        logic [4:0]  sub;
        logic [1:0]  lvl;
        decoded_t    probe_dec;
        exc_cause_e  probe_exc;
        int          errors;
        void'($urandom(34));
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (4) drive("after_reset", 1'b0, 32'b0, 2'd0, NO_WB);
        for (int i = 0; i < 32; i++) begin
            drive("reset_regs", 1'b1, {OP12_STW, 12'($urandom), 5'(i), 5'(31 - i)}, 2'd0, NO_WB);
        end
        drain("reset_regs");

        for (int i = 0; i < 24; i++) begin
            drive("wb_fill", 1'b0, 32'b0, 2'd0, {1'b1, 5'($urandom), 32'($urandom)});
        end
        for (int i = 0; i < 48; i++) begin
            word = {op12_list[i % 8], 12'($urandom), 5'($urandom), 5'($urandom)};
            drive("ri12_ops", 1'b1, word, 2'd0, NO_WB);
        end
        drive("ri12_r0", 1'b1, {OP12_ORI, 12'hfff, 5'd0, 5'd7}, 2'd0, NO_WB);
        drain("ri12_ops");

        for (int i = 0; i < 60; i++) begin
            lvl = (i < 30) ? 2'd0 : 2'($urandom_range(3, 1));
            op8 = (i % 4 == 0) ? OP14_LLW : (i % 4 == 1) ? OP14_SCW : OP14_CSR;
            sub = (i % 3 == 0) ? CSR_SUB_RD : (i % 3 == 1) ? CSR_SUB_WR : 5'($urandom);
            word = {op8, 14'($urandom), sub, 5'($urandom)};
            drive($sformatf("ri14_plv%0d", lvl), 1'b1, word, lvl, NO_WB);
        end
        drain("ri14");

        for (int i = 0; i < 40; i++) begin
            word = $urandom;
            model_decode(word, 2'd0, probe_dec, probe_exc);
            if (!probe_dec.hit) begin
                drive("unknown_op", 1'b1, word, 2'($urandom), NO_WB);
            end
        end
        drain("unknown_op");

        for (int i = 0; i < 32; i++) begin
            r = 5'($urandom_range(31, 1));
            word = {op12_list[i % 8], 12'($urandom), r, r};   // reads the register being written
            drive("bypass", 1'b1, word, 2'd0, {1'b1, r, 32'($urandom)});
        end
        drain("bypass");

        errors = value_errors + latency_errors + timeouts + exp_q.size();
        $display("checks %0d, value errors %0d, latency errors %0d, timeouts %0d, left %0d",
                 checks, value_errors, latency_errors, timeouts, exp_q.size());
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
